/* Makefile */
# Verilator flow for the single-cycle core

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only hdl/cpuPkg.sv hdl/instrDecode.sv hdl/aluExecute.sv \
		hdl/writeBack.sv hdl/srCpu.sv --top-module srCpu
	verilator --lint-only --timing -f src.f --top-module tbSrCpu

sim:
	verilator --binary --timing -f src.f --top-module tbSrCpu -Mdir obj_dir
	./obj_dir/VtbSrCpu | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/aluExecute.sv */
// ALU and branch condition
`timescale 1ns/10ps

module aluExecute import cpuPkg::*; (
    input  logic [XLEN-1:0] srcA,
    input  logic [XLEN-1:0] rd2,
    input  logic [XLEN-1:0] immI,
    input  logic [XLEN-1:0] immS,
    input  logic [1:0]      aluSrc,
    input  logic [2:0]      aluOp,
    input  logic            isBranch,
    input  logic            branchNe,   // bne when set, beq otherwise

    output logic [XLEN-1:0] aluResult,
    output logic            takeBranch
);
    logic [XLEN-1:0] srcB;
    logic            aluZero;

    // operand B mux
    always_comb begin
        case (aluSrc)
            SRC_B_IMM_I: srcB = immI;
            SRC_B_IMM_S: srcB = immS;
            default:     srcB = rd2;
        endcase
    end

    always_comb begin
        case (aluOp)
            ALU_ADD:  aluResult = srcA + srcB;
            ALU_OR:   aluResult = srcA | srcB;
            ALU_SRL:  aluResult = srcA >> srcB[4:0];  // shamt lives in the low bits
            ALU_SLTU: aluResult = {{(XLEN-1){1'b0}}, (srcA < srcB)};
            ALU_SUB:  aluResult = srcA - srcB;
            default:  aluResult = srcA + srcB;
        endcase
    end

    assign aluZero = (aluResult == '0);

    // beq on zero, bne on non-zero
    assign takeBranch = isBranch & (branchNe ? ~aluZero : aluZero);

endmodule

/* hdl/cpuPkg.sv */
// core constants and encodings
package cpuPkg;

    // widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes of the supported instruction classes
    localparam logic [6:0] OP_REG    = 7'b0110011;  // add, sub, or, sltu
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // addi, srli
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq, bne
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw only

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ALU operations
    localparam logic [2:0] ALU_ADD  = 3'b000;
    localparam logic [2:0] ALU_OR   = 3'b001;
    localparam logic [2:0] ALU_SRL  = 3'b010;
    localparam logic [2:0] ALU_SLTU = 3'b011;
    localparam logic [2:0] ALU_SUB  = 3'b100;  // also the branch compare

    // operand B source
    localparam logic [1:0] SRC_B_REG   = 2'b00;
    localparam logic [1:0] SRC_B_IMM_I = 2'b01;
    localparam logic [1:0] SRC_B_IMM_S = 2'b10;

endpackage

/* hdl/instrDecode.sv */
// instruction decoder
`timescale 1ns/10ps

module instrDecode import cpuPkg::*; (
    input  logic [XLEN-1:0]       instr,

    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]       immI,
    output logic [XLEN-1:0]       immS,
    output logic [XLEN-1:0]       immB,
    output logic [XLEN-1:0]       immU,

    output logic                  regWrite,
    output logic [1:0]            aluSrc,
    output logic [2:0]            aluOp,
    output logic                  wdSrc,     // 1 selects the U immediate
    output logic                  memWrite,
    output logic                  isBranch,
    output logic                  branchNe
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // fixed field positions
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // immediates, sign taken from bit 31
    assign immI = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign immS = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        // safe defaults, nothing changes state
        regWrite = 1'b0;
        aluSrc   = SRC_B_REG;
        aluOp    = ALU_ADD;
        wdSrc    = 1'b0;
        memWrite = 1'b0;
        isBranch = 1'b0;
        branchNe = 1'b0;

        case (opcode)
            OP_REG: begin
                case (funct3)
                    F3_ADD: begin
                        if (funct7 == F7_SUB) begin
                            aluOp    = ALU_SUB;
                            regWrite = 1'b1;
                        end else if (funct7 == '0) begin
                            aluOp    = ALU_ADD;
                            regWrite = 1'b1;
                        end
                    end
                    F3_OR: begin
                        aluOp    = ALU_OR;
                        regWrite = (funct7 == '0);
                    end
                    F3_SLTU: begin
                        aluOp    = ALU_SLTU;
                        regWrite = (funct7 == '0);
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OP_IMM: begin
                aluSrc = SRC_B_IMM_I;
                case (funct3)
                    F3_ADD: begin
                        aluOp    = ALU_ADD;  // addi
                        regWrite = 1'b1;
                    end
                    F3_SRL: begin
                        aluOp    = ALU_SRL;
                        regWrite = (funct7 == '0);  // srai not supported
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OP_LUI: begin
                wdSrc    = 1'b1;
                regWrite = 1'b1;
            end
            OP_BRANCH: begin
                aluOp    = ALU_SUB;  // zero result means equal
                isBranch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branchNe = (funct3 == F3_BNE);
            end
            OP_STORE: begin
                aluSrc   = SRC_B_IMM_S;  // address is rs1 + immS
                memWrite = (funct3 == F3_SW);
            end
            default: ;
        endcase
    end

endmodule

/* hdl/srCpu.sv */
// single-cycle RISC-V core
`timescale 1ns/10ps

module srCpu import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,

    // instruction memory
    output logic                  imReq,
    output logic [XLEN-1:0]       imAddr,    // word address
    input  logic [XLEN-1:0]       imData,
    input  logic                  imDrdy,

    // debug port
    input  logic [REG_ADDR_W-1:0] regAddr,
    output logic [XLEN-1:0]       regData,

    // data memory write
    output logic [XLEN-1:0]       memAddr,
    output logic [XLEN-1:0]       memData,
    output logic                  memWrite
);
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       immI;
    logic [XLEN-1:0]       immS;
    logic [XLEN-1:0]       immB;
    logic [XLEN-1:0]       immU;

    logic                  regWrite;
    logic [1:0]            aluSrc;
    logic [2:0]            aluOp;
    logic                  wdSrc;
    logic                  storeDec;   // decoded sw, not yet qualified
    logic                  isBranch;
    logic                  branchNe;

    logic [XLEN-1:0]       aluResult;
    logic                  takeBranch;
    logic [XLEN-1:0]       rd0;
    logic [XLEN-1:0]       rd1;
    logic [XLEN-1:0]       rd2;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pcNext;
    logic                  outOfReset;
    logic                  fetchStarted;

    // program counter
    assign pcNext = takeBranch ? (pc + immB) : (pc + XLEN'(4));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (imDrdy) begin
            pc <= pcNext;  // instruction retires here
        end
    end

    // one-shot kick for the very first fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outOfReset   <= 1'b0;
            fetchStarted <= 1'b0;
        end else begin
            outOfReset   <= 1'b1;
            fetchStarted <= outOfReset;
        end
    end

    // next request goes out in the same cycle the answer arrives
    assign imReq  = imDrdy | (outOfReset & ~fetchStarted);
    assign imAddr = imDrdy ? (pcNext >> 2) : (pc >> 2);

    instrDecode instrDecode_inst (
        .instr    (imData),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .immI     (immI),
        .immS     (immS),
        .immB     (immB),
        .immU     (immU),
        .regWrite (regWrite),
        .aluSrc   (aluSrc),
        .aluOp    (aluOp),
        .wdSrc    (wdSrc),
        .memWrite (storeDec),
        .isBranch (isBranch),
        .branchNe (branchNe)
    );

    aluExecute aluExecute_inst (
        .srcA       (rd1),
        .rd2        (rd2),
        .immI       (immI),
        .immS       (immS),
        .aluSrc     (aluSrc),
        .aluOp      (aluOp),
        .isBranch   (isBranch),
        .branchNe   (branchNe),
        .aluResult  (aluResult),
        .takeBranch (takeBranch)
    );

    writeBack writeBack_inst (
        .clk       (clk),
        .rstN      (rstN),
        .we        (regWrite & imDrdy),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .aluResult (aluResult),
        .immU      (immU),
        .wdSrc     (wdSrc),
        .regAddr   (regAddr),
        .rd1       (rd1),
        .rd2       (rd2),
        .rd0       (rd0)
    );

    // address 0 shows the pc
    assign regData = (regAddr != '0) ? rd0 : pc;

    // store port, valid only with imDrdy
    assign memAddr  = aluResult;
    assign memData  = rd2;
    assign memWrite = storeDec & imDrdy;

endmodule

/* hdl/writeBack.sv */
// write-back and register file
`timescale 1ns/10ps

module writeBack import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,

    input  logic                  we,        // already qualified by the fetch strobe
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       aluResult,
    input  logic [XLEN-1:0]       immU,
    input  logic                  wdSrc,
    input  logic [REG_ADDR_W-1:0] regAddr,   // debug read address

    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2,
    output logic [XLEN-1:0]       rd0
);
    logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];  // x0 has no storage
    logic [XLEN-1:0] wd;

    assign wd = wdSrc ? immU : aluResult;  // lui writes the U immediate

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // combinational reads with x0 tied to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];
    assign rd0 = (regAddr == '0) ? '0 : regs[regAddr];

endmodule

/* src.f */
+incdir+tb
hdl/cpuPkg.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/writeBack.sv
hdl/srCpu.sv
tb/tbSrCpu.sv

/* tb/isaModel.svh */
// instruction-level reference model
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] modelRegs [0:31];  // entry 0 is never written
logic [31:0] modelPc;

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[5'(i)] = '0;
    end
    modelPc = '0;
endtask

// executes one instruction and commits pc and register
task automatic stepModel(
    input  logic [31:0] instr,
    output logic        doStore,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData
);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] result;
    logic        doWrite;
    logic [31:0] nextPc;

    opcode = instr[6:0];
    rd     = instr[11:7];
    f3     = instr[14:12];
    f7     = instr[31:25];
    rs1Val = modelRegs[instr[19:15]];
    rs2Val = modelRegs[instr[24:20]];
    immI   = {{20{instr[31]}}, instr[31:20]};
    immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    result    = '0;
    doWrite   = 1'b0;
    doStore   = 1'b0;
    storeAddr = '0;
    storeData = '0;
    nextPc    = modelPc + 32'd4;

    case (opcode)
        7'b0110011: begin  // register ops
            doWrite = 1'b1;
            if (f3 == 3'b000 && f7 == 7'b0000000) result = rs1Val + rs2Val;
            else if (f3 == 3'b000 && f7 == 7'b0100000) result = rs1Val - rs2Val;
            else if (f3 == 3'b110 && f7 == 7'b0000000) result = rs1Val | rs2Val;
            else if (f3 == 3'b011 && f7 == 7'b0000000) result = {31'b0, rs1Val < rs2Val};
            else doWrite = 1'b0;
        end
        7'b0010011: begin
            if (f3 == 3'b000) begin
                doWrite = 1'b1;
                result  = rs1Val + immI;
            end else if (f3 == 3'b101 && f7 == 7'b0000000) begin
                doWrite = 1'b1;
                result  = rs1Val >> instr[24:20];  // srli
            end
        end
        7'b0110111: begin
            doWrite = 1'b1;
            result  = {instr[31:12], 12'b0};
        end
        7'b1100011: begin
            if ((f3 == 3'b000 && rs1Val == rs2Val) || (f3 == 3'b001 && rs1Val != rs2Val)) begin
                nextPc = modelPc + immB;
            end
        end
        7'b0100011: begin
            if (f3 == 3'b010) begin
                doStore   = 1'b1;
                storeAddr = rs1Val + immS;
                storeData = rs2Val;
            end
        end
        default: ;
    endcase

    if (doWrite && rd != 5'd0) begin
        modelRegs[rd] = result;
    end
    modelPc = nextPc;
endtask

`endif

/* tb/tbSrCpu.sv */
// single-cycle core testbench
`timescale 1ns/10ps

module tbSrCpu;

    localparam int PROG_LEN    = 64;    // random instructions before the final loop
    localparam int MAX_LATENCY = 4;
    localparam int RUN_LIMIT   = 2000;  // cycles for the whole program
    localparam int IDLE_LIMIT  = 8;     // cycles with neither request nor answer

    logic        clk;
    logic        rstN;
    logic        imReq;
    logic [31:0] imAddr;
    logic [31:0] imData;
    logic        imDrdy;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic [31:0] memAddr;
    logic [31:0] memData;
    logic        memWrite;

    integer      seed;
    int          errors;
    int          checks;
    logic [31:0] progMem [0:PROG_LEN];
    logic [31:0] reqAddr;     // word address of the open request
    logic        pending;
    int          countdown;   // cycles until the answer
    logic        reachedEnd;

    `include "isaModel.svh"

    srCpu srCpu_inst (
        .clk      (clk),
        .rstN     (rstN),
        .imReq    (imReq),
        .imAddr   (imAddr),
        .imData   (imData),
        .imDrdy   (imDrdy),
        .regAddr  (regAddr),
        .regData  (regData),
        .memAddr  (memAddr),
        .memData  (memData),
        .memWrite (memWrite)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic int unsigned pickBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // one legal instruction with forward branches only
    function automatic logic [31:0] randomInstr(input int idx);
        int unsigned kind;
        int unsigned span;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [12:0] off;
        logic [31:0] word;

        kind = pickBelow(10);
        rd   = 5'(pickBelow(32));
        rs1  = 5'(pickBelow(32));
        rs2  = 5'(pickBelow(32));
        imm  = 12'(pickBelow(4096));
        span = PROG_LEN - idx;
        if (span > 4) begin
            span = 4;
        end
        off = 13'(4 * (1 + pickBelow(span)));  // target stays inside the program
        case (kind)
            0: word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};  // add
            1: word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};  // sub
            2: word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};  // or
            3: word = {7'b0000000, rs2, rs1, 3'b011, rd, 7'b0110011};  // sltu
            4: word = {imm, rs1, 3'b000, rd, 7'b0010011};              // addi
            5: word = {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0010011};  // srli with rs2 as shamt
            6: word = {20'(pickBelow(1 << 20)), rd, 7'b0110111};       // lui
            7: word = {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
            8: word = {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
            default: word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
        endcase
        return word;
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < PROG_LEN; i++) begin
            progMem[7'(i)] = randomInstr(i);
        end
        progMem[PROG_LEN] = 32'h0000_0063;  // beq x0,x0,0
    endtask

    // every debug address reads zero right after reset
    task automatic checkResetState();
        for (int a = 0; a < 32; a++) begin
            regAddr = 5'(a);
            #0.25;
            checkValue($sformatf("regData[x%0d]", a), regData, 32'h0);
        end
        regAddr = '0;
    endtask

    // runs at the rising edge that ends an imDrdy cycle
    task automatic retireInstr();
        logic        expStore;
        logic [31:0] expAddr;
        logic [31:0] expData;

        checkValue("fetch address", reqAddr, modelPc >> 2);
        stepModel(imData, expStore, expAddr, expData);
        checkValue("memWrite", 32'(memWrite), 32'(expStore));
        if (expStore) begin
            checkValue("memAddr", memAddr, expAddr);
            checkValue("memData", memData, expData);
        end
        checkValue("imReq", 32'(imReq), 32'h1);
        checkValue("imAddr", imAddr, modelPc >> 2);  // next request follows the branch rule
        if (reqAddr == 32'(PROG_LEN)) begin
            reachedEnd = 1'b1;
        end
    endtask

    // memory model and retire checks per clock
    task automatic runProgram();
        int   cycles;
        int   idle;
        logic firstReq;

        cycles   = 0;
        idle     = 0;
        firstReq = 1'b1;
        while (!reachedEnd && cycles < RUN_LIMIT && idle <= IDLE_LIMIT) begin
            @(posedge clk);
            cycles++;
            idle++;
            if (imDrdy) begin
                retireInstr();
                idle = 0;
            end else begin
                checkValue("memWrite", 32'(memWrite), 32'h0);  // store strobe only with imDrdy
            end
            if (imReq) begin
                if (pending) begin
                    errors++;
                    $display("Second fetch request at %0t before the open one was answered",
                             $time);
                end
                if (firstReq) begin
                    checkValue("first imAddr", imAddr, 32'h0);
                    firstReq = 1'b0;
                end
                reqAddr   = imAddr;
                pending   = 1'b1;
                countdown = 1 + int'(pickBelow(MAX_LATENCY));
                idle      = 0;
            end
            @(negedge clk);
            imDrdy = 1'b0;
            if (pending && !reachedEnd) begin
                countdown--;
                if (countdown == 0) begin
                    if (reqAddr > 32'(PROG_LEN)) begin
                        errors++;
                        $display("Fetch from word address %0d outside the program at %0t",
                                 reqAddr, $time);
                        imData = '0;
                    end else begin
                        imData = progMem[7'(reqAddr)];
                    end
                    imDrdy  = 1'b1;
                    pending = 1'b0;
                end
            end
        end
        if (!reachedEnd) begin
            errors++;
            if (idle > IDLE_LIMIT) begin
                $display("Timeout: the core stopped requesting instructions at %0t", $time);
            end else begin
                $display("Timeout: the program did not reach its final loop in %0d cycles",
                         RUN_LIMIT);
            end
        end
    endtask

    // debug port against the model for each address in turn
    task automatic checkFinalState();
        for (int a = 1; a < 32; a++) begin
            regAddr = 5'(a);
            @(posedge clk);
            checkValue($sformatf("regData[x%0d]", a), regData, modelRegs[5'(a)]);
            @(negedge clk);
        end
        regAddr = '0;
        @(posedge clk);
        checkValue("regData[pc]", regData, modelPc);
    endtask

    initial begin
        seed       = 68400;
        errors     = 0;
        checks     = 0;
        rstN       = 1'b0;
        imData     = '0;
        imDrdy     = 1'b0;
        regAddr    = '0;
        reqAddr    = '0;
        pending    = 1'b0;
        countdown  = 0;
        reachedEnd = 1'b0;
        buildProgram();
        resetModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkResetState();
        runProgram();
        if (reachedEnd) begin
            checkFinalState();
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
